// ==== hdl/line_buffer_pkg.sv ====
package line_buffer_pkg;

    // Row command, sampled by the controller while idle
    typedef enum logic [1:0] {
        ROW_NONE  = 2'd0,
        ROW_FIRST = 2'd1,
        ROW_MID   = 2'd2,
        ROW_LAST  = 2'd3
    } row_cmd_e;

    // Source of the column shifted into the window
    typedef enum logic [1:0] {
        COL_ZERO       = 2'd0,
        COL_STREAM     = 2'd1,
        COL_BOTTOM_PAD = 2'd2
    } col_src_e;

    // Row sequencer states
    typedef enum logic [2:0] {
        S_IDLE         = 3'd0,
        S_FIRST_STREAM = 3'd1,
        S_FIRST_DONE   = 3'd2,
        S_PAD_LEFT     = 3'd3,
        S_MID_STREAM   = 3'd4,
        S_LAST_STREAM  = 3'd5,
        S_PAD_RIGHT    = 3'd6,
        S_ROW_DONE     = 3'd7
    } ctrl_state_e;

    // Default image geometry
    localparam int DEFAULT_PIX_W     = 8;
    localparam int DEFAULT_IMG_WIDTH = 16;

    // Column index width, enough for rows up to 128 pixels
    localparam int COL_W = 7;

endpackage

// ==== hdl/line_ctrl.sv ====
module line_ctrl #(
    parameter int IMG_WIDTH = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  line_buffer_pkg::row_cmd_e         row_cmd,
    input  logic                              s_axis_tvalid,
    input  logic                              win_free,
    output logic                              s_axis_tready,
    output logic                              done_row,
    output logic [line_buffer_pkg::COL_W-1:0] col_idx,
    output logic                              ram_we,
    output logic                              first_row,
    output logic                              shift,
    output line_buffer_pkg::col_src_e         col_src,
    output logic                              emit,
    output logic                              emit_last
);

    line_buffer_pkg::ctrl_state_e state;

    // Set when the current row command is the bottom row
    logic last_row;
    logic col_step;
    logic last_col;

    assign last_col = (int'(col_idx) == IMG_WIDTH - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= line_buffer_pkg::S_IDLE;
            col_idx  <= '0;
            last_row <= 1'b0;
        end else begin
            // Column counter wraps at the end of every row
            if (col_step) begin
                col_idx <= last_col ? '0 : col_idx + 1'b1;
            end

            case (state)
                line_buffer_pkg::S_IDLE: begin
                    case (row_cmd)
                        line_buffer_pkg::ROW_FIRST: begin
                            state <= line_buffer_pkg::S_FIRST_STREAM;
                        end
                        line_buffer_pkg::ROW_MID: begin
                            last_row <= 1'b0;
                            state    <= line_buffer_pkg::S_PAD_LEFT;
                        end
                        line_buffer_pkg::ROW_LAST: begin
                            last_row <= 1'b1;
                            state    <= line_buffer_pkg::S_PAD_LEFT;
                        end
                        default: begin
                            state <= line_buffer_pkg::S_IDLE;
                        end
                    endcase
                end

                line_buffer_pkg::S_FIRST_STREAM: begin
                    if (col_step && last_col) begin
                        state <= line_buffer_pkg::S_FIRST_DONE;
                    end
                end

                line_buffer_pkg::S_FIRST_DONE: begin
                    state <= line_buffer_pkg::S_IDLE;
                end

                line_buffer_pkg::S_PAD_LEFT: begin
                    if (win_free) begin
                        state <= last_row ? line_buffer_pkg::S_LAST_STREAM
                                          : line_buffer_pkg::S_MID_STREAM;
                    end
                end

                line_buffer_pkg::S_MID_STREAM,
                line_buffer_pkg::S_LAST_STREAM: begin
                    if (col_step && last_col) begin
                        state <= line_buffer_pkg::S_PAD_RIGHT;
                    end
                end

                line_buffer_pkg::S_PAD_RIGHT: begin
                    if (win_free) begin
                        state <= line_buffer_pkg::S_ROW_DONE;
                    end
                end

                line_buffer_pkg::S_ROW_DONE: begin
                    // Output register empties in this cycle
                    if (win_free) begin
                        state <= line_buffer_pkg::S_IDLE;
                    end
                end

                default: begin
                    state <= line_buffer_pkg::S_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        s_axis_tready = 1'b0;
        done_row      = 1'b0;
        ram_we        = 1'b0;
        first_row     = 1'b0;
        shift         = 1'b0;
        col_src       = line_buffer_pkg::COL_ZERO;
        emit          = 1'b0;
        emit_last     = 1'b0;
        col_step      = 1'b0;

        case (state)
            line_buffer_pkg::S_FIRST_STREAM: begin
                // Store only, with a zero row above
                s_axis_tready = win_free;
                first_row     = 1'b1;
                if (s_axis_tvalid && win_free) begin
                    ram_we   = 1'b1;
                    col_step = 1'b1;
                end
            end

            line_buffer_pkg::S_FIRST_DONE: begin
                done_row = 1'b1;
            end

            line_buffer_pkg::S_PAD_LEFT: begin
                shift = win_free;
            end

            line_buffer_pkg::S_MID_STREAM: begin
                s_axis_tready = win_free;
                col_src       = line_buffer_pkg::COL_STREAM;
                if (s_axis_tvalid && win_free) begin
                    ram_we   = 1'b1;
                    shift    = 1'b1;
                    emit     = (col_idx != '0);
                    col_step = 1'b1;
                end
            end

            line_buffer_pkg::S_LAST_STREAM: begin
                // No input, stored rows over a zero bottom row
                col_src = line_buffer_pkg::COL_BOTTOM_PAD;
                if (win_free) begin
                    shift    = 1'b1;
                    emit     = (col_idx != '0);
                    col_step = 1'b1;
                end
            end

            line_buffer_pkg::S_PAD_RIGHT: begin
                if (win_free) begin
                    shift     = 1'b1;
                    emit      = 1'b1;
                    emit_last = 1'b1;
                end
            end

            line_buffer_pkg::S_ROW_DONE: begin
                done_row = win_free;
            end

            default: begin
                done_row = 1'b0;
            end
        endcase
    end

endmodule

// ==== hdl/line_ram.sv ====
module line_ram #(
    parameter int PIX_W     = 8,
    parameter int IMG_WIDTH = 16
) (
    input  logic                              clk,
    input  logic [line_buffer_pkg::COL_W-1:0] col_idx,
    input  logic                              ram_we,
    input  logic                              first_row,
    input  logic [PIX_W-1:0]                  s_axis_tdata,
    output logic [PIX_W-1:0]                  row_n1,
    output logic [PIX_W-1:0]                  row_n2
);

    localparam int ADDR_W = $clog2(IMG_WIDTH);

    // Each word holds {older row, upper row} for one column
    logic [2*PIX_W-1:0] mem [IMG_WIDTH];
    logic [2*PIX_W-1:0] rd_word;
    logic [ADDR_W-1:0]  addr;
    logic [PIX_W-1:0]   older_in;

    assign addr = col_idx[ADDR_W-1:0];

    // Asynchronous read of the current column
    assign rd_word = mem[addr];
    assign row_n1  = rd_word[PIX_W-1:0];
    assign row_n2  = rd_word[2*PIX_W-1:PIX_W];

    // Top padding row enters as the older row
    assign older_in = first_row ? '0 : row_n1;

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[addr] <= {older_in, s_axis_tdata};
        end
    end

endmodule

// ==== hdl/window_regs.sv ====
module window_regs #(
    parameter int PIX_W = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      shift,
    input  line_buffer_pkg::col_src_e col_src,
    input  logic                      emit,
    input  logic                      emit_last,
    input  logic [PIX_W-1:0]          row_n1,
    input  logic [PIX_W-1:0]          row_n2,
    input  logic [PIX_W-1:0]          s_axis_tdata,
    input  logic                      m_axis_tready,
    output logic                      win_free,
    output logic [9*PIX_W-1:0]        m_axis_tdata,
    output logic                      m_axis_tvalid,
    output logic                      m_axis_tlast
);

    // Indexed [column][row], column 0 is the oldest (dc = -1)
    logic [PIX_W-1:0]   win      [3][3];
    logic [PIX_W-1:0]   next_win [3][3];
    logic [PIX_W-1:0]   new_col  [3];
    logic [9*PIX_W-1:0] next_flat;

    assign win_free = !m_axis_tvalid || m_axis_tready;

    // Incoming column, top to bottom
    always_comb begin
        case (col_src)
            line_buffer_pkg::COL_STREAM: begin
                new_col[0] = row_n2;
                new_col[1] = row_n1;
                new_col[2] = s_axis_tdata;
            end
            line_buffer_pkg::COL_BOTTOM_PAD: begin
                new_col[0] = row_n2;
                new_col[1] = row_n1;
                new_col[2] = '0;
            end
            default: begin
                new_col[0] = '0;
                new_col[1] = '0;
                new_col[2] = '0;
            end
        endcase
    end

    always_comb begin
        next_win[0] = win[1];
        next_win[1] = win[2];
        next_win[2] = new_col;
    end

    // Lane (dr+1)*3 + (dc+1), lane 0 in the low bits
    always_comb begin
        next_flat = '0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                next_flat[(r*3+c)*PIX_W +: PIX_W] = next_win[c][r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            win <= next_win;
        end
    end

    always_ff @(posedge clk) begin
        if (shift && emit) begin
            m_axis_tdata <= next_flat;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
        end else if (shift && emit) begin
            m_axis_tvalid <= 1'b1;
            m_axis_tlast  <= emit_last;
        end else if (m_axis_tready) begin
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
        end
    end

endmodule

// ==== hdl/line_buffer_top.sv ====
module line_buffer_top #(
    parameter int PIX_W     = line_buffer_pkg::DEFAULT_PIX_W,
    parameter int IMG_WIDTH = line_buffer_pkg::DEFAULT_IMG_WIDTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  line_buffer_pkg::row_cmd_e row_cmd,
    input  logic [PIX_W-1:0]          s_axis_tdata,
    input  logic                      s_axis_tvalid,
    output logic                      s_axis_tready,
    output logic [9*PIX_W-1:0]        m_axis_tdata,
    output logic                      m_axis_tvalid,
    input  logic                      m_axis_tready,
    output logic                      m_axis_tlast,
    output logic                      done_row
);

    // Controller to memory
    logic [line_buffer_pkg::COL_W-1:0] col_idx;
    logic                              ram_we;
    logic                              first_row;

    // Memory to window
    logic [PIX_W-1:0] row_n1;
    logic [PIX_W-1:0] row_n2;

    // Controller and window handshake
    logic                      win_free;
    logic                      shift;
    line_buffer_pkg::col_src_e col_src;
    logic                      emit;
    logic                      emit_last;

    line_ctrl #(
        .IMG_WIDTH(IMG_WIDTH)
    ) line_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .row_cmd      (row_cmd),
        .s_axis_tvalid(s_axis_tvalid),
        .win_free     (win_free),
        .s_axis_tready(s_axis_tready),
        .done_row     (done_row),
        .col_idx      (col_idx),
        .ram_we       (ram_we),
        .first_row    (first_row),
        .shift        (shift),
        .col_src      (col_src),
        .emit         (emit),
        .emit_last    (emit_last)
    );

    line_ram #(
        .PIX_W    (PIX_W),
        .IMG_WIDTH(IMG_WIDTH)
    ) line_ram_i (
        .clk         (clk),
        .col_idx     (col_idx),
        .ram_we      (ram_we),
        .first_row   (first_row),
        .s_axis_tdata(s_axis_tdata),
        .row_n1      (row_n1),
        .row_n2      (row_n2)
    );

    window_regs #(
        .PIX_W(PIX_W)
    ) window_regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .shift        (shift),
        .col_src      (col_src),
        .emit         (emit),
        .emit_last    (emit_last),
        .row_n1       (row_n1),
        .row_n2       (row_n2),
        .s_axis_tdata (s_axis_tdata),
        .m_axis_tready(m_axis_tready),
        .win_free     (win_free),
        .m_axis_tdata (m_axis_tdata),
        .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tlast (m_axis_tlast)
    );

endmodule

// ==== testbench/line_buffer_assertions.sv ====
module line_buffer_assertions #(
    parameter int PIX_W = 8
) (
    input logic                         clk,
    input logic                         rst_n,
    input line_buffer_pkg::ctrl_state_e state,
    input logic                         s_axis_tready,
    input logic [9*PIX_W-1:0]           m_axis_tdata,
    input logic                         m_axis_tvalid,
    input logic                         m_axis_tready,
    input logic                         m_axis_tlast,
    input logic                         done_row
);
    timeunit 1ns;
    timeprecision 1ps;

    // Output word held while the sink stalls
    output_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        (m_axis_tvalid && !m_axis_tready) |=>
            (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
        else $error("m_axis output changed while the sink stalled");

    idle_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
        (state == line_buffer_pkg::S_IDLE) |-> !s_axis_tready)
        else $error("s_axis_tready high in the idle state");

    done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        done_row |=> !done_row)
        else $error("done_row held for more than one cycle");

endmodule

bind line_buffer_top line_buffer_assertions #(
    .PIX_W(PIX_W)
) line_buffer_assertions_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .state        (line_ctrl_i.state),
    .s_axis_tready(s_axis_tready),
    .m_axis_tdata (m_axis_tdata),
    .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tready(m_axis_tready),
    .m_axis_tlast (m_axis_tlast),
    .done_row     (done_row)
);

// ==== testbench/tb_line_buffer.sv ====
module tb_line_buffer;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PIX_W      = line_buffer_pkg::DEFAULT_PIX_W;
    localparam int IMG_WIDTH  = line_buffer_pkg::DEFAULT_IMG_WIDTH;
    localparam int CLK_PERIOD = 100;
    localparam int NUM_FRAMES = 6;
    localparam int MIN_ROWS   = 3;
    localparam int MAX_ROWS   = 6;
    // One command per row plus the bottom padding command
    localparam longint TIMEOUT_NS =
        longint'(NUM_FRAMES) * (MAX_ROWS + 1) * (IMG_WIDTH + 4) * 4 * CLK_PERIOD;

    logic                      clk;
    logic                      rst_n;
    line_buffer_pkg::row_cmd_e row_cmd;
    logic [PIX_W-1:0]          s_axis_tdata;
    logic                      s_axis_tvalid;
    logic                      s_axis_tready;
    logic [9*PIX_W-1:0]        m_axis_tdata;
    logic                      m_axis_tvalid;
    logic                      m_axis_tready;
    logic                      m_axis_tlast;
    logic                      done_row;

    // Current frame and its windows in raster order
    logic [PIX_W-1:0]   img [MAX_ROWS][IMG_WIDTH];
    int                 frame_rows;
    logic [9*PIX_W-1:0] exp_win_q [$];
    logic               exp_last_q [$];
    int                 frame_windows;
    int                 done_count;
    int                 cmd_count;
    logic               stall_en;

    line_buffer_top #(
        .PIX_W    (PIX_W),
        .IMG_WIDTH(IMG_WIDTH)
    ) line_buffer_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .row_cmd      (row_cmd),
        .s_axis_tdata (s_axis_tdata),
        .s_axis_tvalid(s_axis_tvalid),
        .s_axis_tready(s_axis_tready),
        .m_axis_tdata (m_axis_tdata),
        .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tready(m_axis_tready),
        .m_axis_tlast (m_axis_tlast),
        .done_row     (done_row)
    );

    task automatic report_error(string msg);
        $display("Error: %0d ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_window(logic [9*PIX_W-1:0] got, logic [9*PIX_W-1:0] exp);
        if (got !== exp) begin
            report_error($sformatf("window mismatch, got %h expected %h", got, exp));
        end
    endtask

    task automatic check_last(logic got, logic exp);
        if (got !== exp) begin
            report_error($sformatf("tlast mismatch, got %b expected %b", got, exp));
        end
    endtask

    task automatic check_count(string what, int got, int exp);
        if (got != exp) begin
            report_error($sformatf("%s, got %0d expected %0d", what, got, exp));
        end
    endtask

    // Zero outside the image on all four sides
    function automatic logic [PIX_W-1:0] padded_pixel(int r, int c);
        if (r < 0 || r >= frame_rows || c < 0 || c >= IMG_WIDTH) begin
            return '0;
        end
        return img[r][c];
    endfunction

    task automatic build_expected();
        logic [9*PIX_W-1:0] win;
        for (int y = 0; y < frame_rows; y++) begin
            for (int x = 0; x < IMG_WIDTH; x++) begin
                win = '0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        win[((dr + 1) * 3 + dc + 1) * PIX_W +: PIX_W] =
                            padded_pixel(y + dr, x + dc);
                    end
                end
                exp_win_q.push_back(win);
                exp_last_q.push_back(x == IMG_WIDTH - 1);
            end
        end
    endtask

    task automatic issue_command(line_buffer_pkg::row_cmd_e cmd);
        @(posedge clk);
        row_cmd <= cmd;
        @(posedge clk);
        row_cmd <= line_buffer_pkg::ROW_NONE;
        cmd_count++;
    endtask

    task automatic send_row(int r);
        for (int c = 0; c < IMG_WIDTH; c++) begin
            if (stall_en && ($urandom % 4 == 0)) begin
                repeat (1 + $urandom % 3) begin
                    @(posedge clk);
                    s_axis_tvalid <= 1'b0;
                end
            end
            @(posedge clk);
            s_axis_tvalid <= 1'b1;
            s_axis_tdata  <= img[r][c];
            do @(negedge clk); while (!s_axis_tready);
        end
        @(posedge clk);
        s_axis_tvalid <= 1'b0;
    endtask

    // Returns after the edge that ends the done_row pulse
    task automatic wait_done();
        do @(negedge clk); while (!done_row);
        @(posedge clk);
    endtask

    task automatic run_frame();
        frame_rows = MIN_ROWS + int'($urandom % (MAX_ROWS - MIN_ROWS + 1));
        for (int r = 0; r < frame_rows; r++) begin
            for (int c = 0; c < IMG_WIDTH; c++) begin
                img[r][c] = PIX_W'($urandom);
            end
        end
        build_expected();
        frame_windows = 0;
        issue_command(line_buffer_pkg::ROW_FIRST);
        send_row(0);
        wait_done();
        check_count("windows after the first row", frame_windows, 0);
        for (int r = 1; r < frame_rows; r++) begin
            issue_command(line_buffer_pkg::ROW_MID);
            send_row(r);
            wait_done();
        end
        issue_command(line_buffer_pkg::ROW_LAST);
        wait_done();
        check_count("windows in frame", frame_windows, frame_rows * IMG_WIDTH);
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : sink_ready
        forever begin
            @(posedge clk);
            m_axis_tready <= stall_en ? ($urandom % 4 != 0) : 1'b1;
        end
    end

    initial begin : output_monitor
        logic [9*PIX_W-1:0] exp_win;
        logic               exp_last;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && m_axis_tvalid && m_axis_tready) begin
                if (exp_win_q.size() == 0) begin
                    report_error("window received with none expected");
                end
                exp_win  = exp_win_q.pop_front();
                exp_last = exp_last_q.pop_front();
                check_window(m_axis_tdata, exp_win);
                check_last(m_axis_tlast, exp_last);
                frame_windows++;
            end
            if (rst_n === 1'b1 && done_row) begin
                done_count++;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS + 20 * CLK_PERIOD);
        $display("Timeout: the DUT stopped responding before all frames were done");
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin : main_sequence
        void'($urandom(32'h673c));
        rst_n         = 1'b0;
        row_cmd       = line_buffer_pkg::ROW_NONE;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b1;
        stall_en      = 1'b0;
        frame_windows = 0;
        done_count    = 0;
        cmd_count     = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // Quiet outputs until the first command
        repeat (3) begin
            @(negedge clk);
            if (s_axis_tready || m_axis_tvalid || done_row) begin
                report_error("outputs active after reset with no command");
            end
        end
        // First frame runs without stalls
        for (int f = 0; f < NUM_FRAMES; f++) begin
            stall_en = (f != 0);
            run_frame();
        end
        check_count("done_row pulses", done_count, cmd_count);
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== line_buffer.f ====
hdl/line_buffer_pkg.sv
hdl/line_ctrl.sv
hdl/line_ram.sv
hdl/window_regs.sv
hdl/line_buffer_top.sv
testbench/line_buffer_assertions.sv
testbench/tb_line_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the line buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_line_buffer -f line_buffer.f -o tb_line_buffer

# The simulator exits non-zero on a fatal error, the log decides
./obj_dir/tb_line_buffer > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation completed"
